//--- logic/board_cfg.svh
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// System clock, MHz.
`define CLK_MHZ     25

// Panel widths are fixed by the TM1638 LED & KEY board.
`define W_TM_DIGIT  8
`define W_TM_LED    8
`define W_TM_KEY    8

// INMP441 sample width.
`define W_MIC       24

// Panel bus, clk cycles per sio_clk half period (about 3 MHz at 25 MHz).
`define SIO_HALF    4

// I2S, clk cycles per sck half period.
`define SCK_HALF    2

`endif

//--- logic/board_pkg.sv
`include "board_cfg.svh"

package board_pkg;

    // Segment byte, bit 7 is segment a, bit 0 the decimal point.
    typedef logic [7:0] seg_t;

    // One-hot digit select, digit 0 is the leftmost.
    typedef logic [`W_TM_DIGIT - 1:0] digit_sel_t;

    typedef logic [`W_TM_LED - 1:0] led_t;    // 1 means lit.
    typedef logic [`W_TM_KEY - 1:0] key_t;    // 1 means held.

    // Two's-complement microphone sample.
    typedef logic signed [`W_MIC - 1:0] mic_sample_t;

endpackage

//--- logic/panel_if.sv
`timescale 1ns/1ps

interface panel_if;

    board_pkg::seg_t       abcdefgh;  // Segments of the selected digit.
    board_pkg::digit_sel_t digit;
    board_pkg::led_t       led;
    board_pkg::key_t       keys;

    // Application side.
    modport app
    (
        output abcdefgh,
        output digit,
        output led,
        input  keys
    );

    // Panel controller side.
    modport ctrl
    (
        input  abcdefgh,
        input  digit,
        input  led,
        output keys
    );

endinterface

//--- logic/inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module inmp441_mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sd,
    output logic                   sck,
    output logic                   ws,
    output board_pkg::mic_sample_t value
);

    localparam int unsigned        div_w    = $clog2(`SCK_HALF);
    localparam logic [div_w - 1:0] div_last = div_w'(`SCK_HALF - 1);

    logic [div_w - 1:0]     div_cnt;
    logic                   sck_edge;
    logic                   sck_rise;
    logic                   sck_fall;
    logic [5:0]             bit_cnt;  // 32 sck periods per channel.
    board_pkg::mic_sample_t shift;
    logic                   load;

    assign sck_edge = (div_cnt == div_last);
    assign sck_rise = sck_edge && !sck;
    assign sck_fall = sck_edge && sck;

    // Low half of the count is the left channel.
    assign ws = bit_cnt[5];

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_edge)
        begin
            div_cnt <= '0;
            sck     <= !sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end

    // Advances on the falling edge, so ws changes there too.
    always_ff @(posedge clk)
        if (!rst_n)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;

    // Rising edge 1 is the I2S delay slot, MSB arrives on edge 2.
    always_ff @(posedge clk)
        if (sck_rise && bit_cnt >= 6'd1 && bit_cnt <= 6'd24)
            shift <= {shift[`W_MIC - 2:0], sd};

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            load  <= 1'b0;
            value <= '0;
        end
        else
        begin
            load <= sck_rise && (bit_cnt == 6'd24);  // LSB just shifted in.
            if (load)
                value <= shift;
        end

endmodule

//--- logic/mic_monitor.sv
`timescale 1ns/1ps

module mic_monitor
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [4:0]             sw,
    input  board_pkg::mic_sample_t mic,
    panel_if.app                   panel
);

    logic [2:0] idx;  // Digit being refreshed.
    logic [3:0] nibble;
    logic [7:0] sw_ext;

    // Hex font, abcdefgh order with the point off.
    function automatic board_pkg::seg_t hex_font(input logic [3:0] h);
        case (h)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'hA:    return 8'b1110_1110;
            4'hB:    return 8'b0011_1110;  // Lower case b.
            4'hC:    return 8'b1001_1100;
            4'hD:    return 8'b0111_1010;  // Lower case d.
            4'hE:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    assign sw_ext = {3'b000, sw};

    // Six sample digits, then two switch digits.
    always_comb
        case (idx)
            3'd0:    nibble = mic[23:20];
            3'd1:    nibble = mic[19:16];
            3'd2:    nibble = mic[15:12];
            3'd3:    nibble = mic[11:8];
            3'd4:    nibble = mic[7:4];
            3'd5:    nibble = mic[3:0];
            3'd6:    nibble = sw_ext[7:4];
            default: nibble = sw_ext[3:0];
        endcase

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            idx            <= '0;
            panel.digit    <= '0;
            panel.abcdefgh <= '0;
            panel.led      <= '0;
        end
        else
        begin
            idx            <= idx + 1'b1;
            panel.digit    <= board_pkg::digit_sel_t'(1) << idx;
            panel.abcdefgh <= hex_font(nibble);
            panel.led      <= panel.keys;  // LED i lit while key i held.
        end

endmodule

//--- logic/tm1638_board_controller.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module tm1638_board_controller
(
    input  logic  clk,
    input  logic  rst_n,
    panel_if.ctrl panel,
    input  logic  sio_data_in,
    output logic  sio_clk,
    output logic  sio_stb,
    output logic  sio_data_out,
    output logic  sio_data_oe
);

    localparam int unsigned        div_w    = $clog2(`SIO_HALF);
    localparam logic [div_w - 1:0] div_last = div_w'(`SIO_HALF - 1);

    // Which command of the refresh loop is on the bus.
    typedef enum logic [2:0]
    {
        st_write_cmd,
        st_addr,
        st_data,
        st_disp_on,
        st_key_cmd,
        st_key_read
    } state_t;

    // Position inside one strobed command, one step per half period.
    typedef enum logic [2:0]
    {
        ph_gap,
        ph_start,
        ph_low,
        ph_high,
        ph_end
    } phase_t;

    state_t               state;
    phase_t               phase;
    logic [div_w - 1:0]   div_cnt;
    logic                 tick;
    logic [2:0]           bit_cnt;
    logic [3:0]           byte_cnt;
    logic [7:0]           tx_byte;
    logic [7:0]           rx_byte;
    logic [7:0]           key_bytes [4];
    logic                 read_done;
    logic                 snap;
    board_pkg::seg_t      seg_live  [`W_TM_DIGIT];
    board_pkg::seg_t      seg_frame [`W_TM_DIGIT];
    board_pkg::led_t      led_frame;
    board_pkg::key_t      keys_next;
    logic [7:0]           cmd_byte;
    logic [3:0]           next_idx;
    logic [7:0]           next_data;

    // Panel wants segment a in bit 0.
    function automatic logic [7:0] rev8(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = b[7 - i];
        return r;
    endfunction

    assign tick         = (div_cnt == div_last);
    assign sio_data_out = tx_byte[0];  // LSB first.
    assign snap         = tick && (phase == ph_gap) && (state == st_addr);

    always_ff @(posedge clk)
        if (!rst_n)
            div_cnt <= '0;
        else if (tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;

    // Catch each digit as the application strobes past it.
    always_ff @(posedge clk)
        if (!rst_n)
        begin
            for (int i = 0; i < `W_TM_DIGIT; i++)
                seg_live[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < `W_TM_DIGIT; i++)
                if (panel.digit[i])
                    seg_live[i] <= panel.abcdefgh;
        end

    always_comb
        case (state)
            st_write_cmd: cmd_byte = 8'h40;  // Write, auto-increment.
            st_addr:      cmd_byte = 8'hC0;  // Start at address 0.
            st_disp_on:   cmd_byte = 8'h8F;  // Display on, full brightness.
            default:      cmd_byte = 8'h42;  // Read keys.
        endcase

    // Even addresses hold segments, odd ones the LED.
    assign next_idx  = (state == st_data) ? byte_cnt + 4'd1 : 4'd0;
    assign next_data = next_idx[0] ? {7'b0, led_frame[next_idx[3:1]]}
                                   : rev8(seg_frame[next_idx[3:1]]);

    // Key byte j carries key j in bit 0 and key j+4 in bit 4.
    always_comb
        for (int j = 0; j < 4; j++)
        begin
            keys_next[j]     = key_bytes[j][0];
            keys_next[j + 4] = key_bytes[j][4];
        end

    always_ff @(posedge clk)
    begin
        if (snap)
        begin
            seg_frame <= seg_live;
            led_frame <= panel.led;
        end

        if (tick && phase == ph_low && state == st_key_read)
            rx_byte <= {sio_data_in, rx_byte[7:1]};  // Sampled at the rising edge.

        if (tick && phase == ph_high && state == st_key_read && bit_cnt == 3'd7)
            key_bytes[byte_cnt[1:0]] <= rx_byte;
    end

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            state       <= st_write_cmd;
            phase       <= ph_gap;
            sio_clk     <= 1'b1;
            sio_stb     <= 1'b1;
            sio_data_oe <= 1'b0;
            tx_byte     <= 8'hFF;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            read_done   <= 1'b0;
            panel.keys  <= '0;
        end
        else if (tick)
        begin
            case (phase)
                ph_gap:
                begin
                    sio_stb     <= 1'b0;  // Frame the next command.
                    sio_data_oe <= 1'b1;
                    tx_byte     <= cmd_byte;
                    bit_cnt     <= '0;
                    phase       <= ph_start;
                end
                ph_start:
                begin
                    sio_clk <= 1'b0;
                    phase   <= ph_low;
                end
                ph_low:
                begin
                    sio_clk <= 1'b1;
                    phase   <= ph_high;
                end
                ph_high:
                    if (bit_cnt != 3'd7)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        tx_byte <= {1'b1, tx_byte[7:1]};
                        sio_clk <= 1'b0;
                        phase   <= ph_low;
                    end
                    else
                    begin
                        bit_cnt <= '0;
                        case (state)
                            st_addr:
                            begin
                                state    <= st_data;
                                byte_cnt <= '0;
                                tx_byte  <= next_data;
                                sio_clk  <= 1'b0;
                                phase    <= ph_low;
                            end
                            st_data:
                                if (byte_cnt == 4'd15)
                                begin
                                    state <= st_disp_on;
                                    phase <= ph_end;
                                end
                                else
                                begin
                                    byte_cnt <= byte_cnt + 1'b1;
                                    tx_byte  <= next_data;
                                    sio_clk  <= 1'b0;
                                    phase    <= ph_low;
                                end
                            st_key_cmd:
                            begin
                                // Release the data line for the chip.
                                state       <= st_key_read;
                                byte_cnt    <= '0;
                                sio_data_oe <= 1'b0;
                                sio_clk     <= 1'b0;
                                phase       <= ph_low;
                            end
                            st_key_read:
                                if (byte_cnt == 4'd3)
                                begin
                                    state     <= st_write_cmd;
                                    read_done <= 1'b1;
                                    phase     <= ph_end;
                                end
                                else
                                begin
                                    byte_cnt <= byte_cnt + 1'b1;
                                    sio_clk  <= 1'b0;
                                    phase    <= ph_low;
                                end
                            st_write_cmd:
                            begin
                                state <= st_addr;
                                phase <= ph_end;
                            end
                            default:
                            begin
                                state <= st_key_cmd;
                                phase <= ph_end;
                            end
                        endcase
                    end
                ph_end:
                begin
                    sio_stb     <= 1'b1;
                    sio_data_oe <= 1'b0;
                    phase       <= ph_gap;
                    if (read_done)
                    begin
                        panel.keys <= keys_next;  // Together with the strobe rise.
                        read_done  <= 1'b0;
                    end
                end
                default:
                    phase <= ph_gap;
            endcase
        end

endmodule

//--- logic/board_specific_top.sv
`timescale 1ns/1ps

module board_specific_top
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [4:0] sw,
    input  logic       sio_data_in,
    input  logic       mic_sd,
    output logic       sio_clk,
    output logic       sio_stb,
    output logic       sio_data_out,
    output logic       sio_data_oe,
    output logic       mic_sck,
    output logic       mic_ws,
    output logic       mic_lr
);

    board_pkg::mic_sample_t mic;

    panel_if panel ();

    assign mic_lr = 1'b0;  // Select the left channel.

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .sd    ( mic_sd  ),
        .sck   ( mic_sck ),
        .ws    ( mic_ws  ),
        .value ( mic     )
    );

    mic_monitor i_monitor
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .sw    ( sw    ),
        .mic   ( mic   ),
        .panel ( panel )
    );

    // Panel refresh runs on its own, sampling the latest digits.
    tm1638_board_controller i_tm1638
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .panel        ( panel        ),
        .sio_data_in  ( sio_data_in  ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  )
    );

endmodule

//--- tb/tm1638_panel_model.sv
`timescale 1ns/1ps

module tm1638_panel_model
(
    input  logic       sio_clk,
    input  logic       sio_stb,
    input  logic       sio_data_out,
    input  logic       sio_data_oe,
    input  logic [7:0] keys,
    output logic       sio_data_in,
    output int         frames
);

    logic [7:0] display [16];  // Even addresses segments, odd ones LEDs.
    logic [7:0] cmd_log [4];   // First byte of each strobe in a frame.
    logic [7:0] shreg;
    logic [3:0] addr;
    logic [2:0] cmd_cnt;
    logic [5:0] rd_bit;
    logic       reading;
    logic       clk_prev;
    logic       stb_prev;
    int         bit_cnt;
    int         byte_cnt;
    int         oe_errors;  // Rising edges with the wrong data line enable.

    // Key byte j carries key j in bit 0 and key j+4 in bit 4.
    function automatic logic key_bit(input logic [4:0] idx);
        if (idx[2:0] == 3'd0)
            return keys[{1'b0, idx[4:3]}];
        else if (idx[2:0] == 3'd4)
            return keys[{1'b1, idx[4:3]}];
        else
            return 1'b0;
    endfunction

    initial
    begin
        for (int i = 0; i < 16; i++)
            display[i] = 8'h00;
        for (int i = 0; i < 4; i++)
            cmd_log[i] = 8'h00;
        shreg       = 8'h00;
        addr        = 4'd0;
        cmd_cnt     = 3'd0;
        rd_bit      = 6'd0;
        reading     = 1'b0;
        clk_prev    = 1'b1;
        stb_prev    = 1'b1;
        bit_cnt     = 0;
        byte_cnt    = 0;
        oe_errors   = 0;
        frames      = 0;
        sio_data_in = 1'b0;
    end

    // Strobe and clock of the controller never move in the same step.
    always @(sio_clk or sio_stb)
    begin
        if (sio_stb !== stb_prev)
        begin
            bit_cnt  = 0;
            byte_cnt = 0;
            if (sio_stb === 1'b1 && reading)
            begin
                reading = 1'b0;  // Key read over, frame complete.
                cmd_cnt = 3'd0;
                frames  = frames + 1;
            end
        end
        else if (sio_clk === 1'b1 && clk_prev === 1'b0 && sio_stb === 1'b0)
        begin
            if (reading)
            begin
                if (sio_data_oe !== 1'b0)
                    oe_errors = oe_errors + 1;  // Controller still drives the line.
            end
            else
            begin
                if (sio_data_oe !== 1'b1)
                    oe_errors = oe_errors + 1;  // Line not driven during a write.
                shreg   = {sio_data_out, shreg[7:1]};  // LSB first.
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8)
                begin
                    bit_cnt = 0;
                    if (byte_cnt == 0)
                    begin
                        if (cmd_cnt < 3'd4)
                            cmd_log[cmd_cnt[1:0]] = shreg;
                        cmd_cnt = cmd_cnt + 3'd1;
                        if (shreg[7:6] == 2'b11)
                            addr = shreg[3:0];  // Address command.
                        if (shreg == 8'h42)
                        begin
                            reading = 1'b1;
                            rd_bit  = 6'd0;
                        end
                    end
                    else
                    begin
                        display[addr] = shreg;
                        addr          = addr + 4'd1;
                    end
                    byte_cnt = byte_cnt + 1;
                end
            end
        end
        else if (sio_clk === 1'b0 && clk_prev === 1'b1 && reading && rd_bit < 6'd32)
        begin
            sio_data_in = key_bit(rd_bit[4:0]);  // Chip shifts out on the falling edge.
            rd_bit      = rd_bit + 6'd1;
        end
        clk_prev = sio_clk;
        stb_prev = sio_stb;
    end

endmodule

//--- tb/tb_board_specific_top.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module tb_board_specific_top;

    localparam int clk_period       = 40;
    localparam int reset_cycles     = 16;
    localparam int n_entries        = 6;
    localparam int i2s_frame_clks   = 64 * 2 * `SCK_HALF;
    // 24 bytes of 16 half periods, plus gap, start and end per strobe.
    localparam int panel_frame_clks = (24 * 16 + 4 * 3) * `SIO_HALF;
    localparam int longest_frame    = (i2s_frame_clks > panel_frame_clks) ? i2s_frame_clks
                                                                          : panel_frame_clks;
    localparam longint timeout_ns   = longint'(n_entries * 4 * longest_frame + reset_cycles)
                                      * clk_period;

    logic       clk;
    logic       rst_n;
    logic [4:0] sw;
    logic       sio_data_in;
    logic       mic_sd;
    logic       sio_clk;
    logic       sio_stb;
    logic       sio_data_out;
    logic       sio_data_oe;
    logic       mic_sck;
    logic       mic_ws;
    logic       mic_lr;

    logic [23:0] cur_sample;
    logic [7:0]  cur_keys;
    int          panel_frames;
    int          left_frames;
    int          fall_cnt;
    logic        sck_prev;
    logic        ws_prev;
    int          errors;
    int          checks;

    logic [23:0] sample_tab [n_entries];
    logic [4:0]  sw_tab     [n_entries];
    logic [7:0]  keys_tab   [n_entries];
    logic [7:0]  font       [16];  // Hex digit segments in abcdefgh order.

    board_specific_top i_board_specific_top
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sw           ( sw           ),
        .sio_data_in  ( sio_data_in  ),
        .mic_sd       ( mic_sd       ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .mic_lr       ( mic_lr       )
    );

    tm1638_panel_model i_panel
    (
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .keys         ( cur_keys     ),
        .sio_data_in  ( sio_data_in  ),
        .frames       ( panel_frames )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Panel expects segment a in bit 0.
    function automatic logic [7:0] panel_seg(input logic [3:0] n);
        logic [7:0] f;
        f = font[n];
        return {<<{f}};
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks = checks + 1;
        if (actual !== expected)
        begin
            errors = errors + 1;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic check_entry(input logic [2:0] e);
        logic [3:0] nib;
        logic [7:0] sw_ext;
        logic [7:0] cmd_exp [4];
        cmd_exp = '{8'h40, 8'hC0, 8'h8F, 8'h42};
        for (int k = 0; k < 6; k++)
        begin
            nib = 4'(sample_tab[e] >> (4 * (5 - k)));  // Digit 0 holds the top nibble.
            check($sformatf("display[%0d]", 2 * k), 32'(i_panel.display[4'(2 * k)]),
                  32'(panel_seg(nib)));
        end
        sw_ext = {3'b000, sw_tab[e]};
        check("display[12]", 32'(i_panel.display[4'd12]), 32'(panel_seg(sw_ext[7:4])));
        check("display[14]", 32'(i_panel.display[4'd14]), 32'(panel_seg(sw_ext[3:0])));
        for (int k = 0; k < 8; k++)
            check($sformatf("display[%0d]", 2 * k + 1), 32'(i_panel.display[4'(2 * k + 1)]),
                  32'(keys_tab[e][3'(k)]));
        for (int k = 0; k < 4; k++)
            check($sformatf("command[%0d]", k), 32'(i_panel.cmd_log[2'(k)]),
                  32'(cmd_exp[2'(k)]));
        check("sio_data_oe error count", 32'(i_panel.oe_errors), 32'd0);
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #(clk_period / 2) clk = ~clk;
    end

    // I2S microphone drives a new bit after each falling sck edge.
    initial
    begin
        mic_sd      = 1'b0;
        sck_prev    = 1'b0;
        ws_prev     = 1'b0;
        fall_cnt    = 0;
        left_frames = 0;
        forever
        begin
            @(posedge clk);
            #2;
            if (sck_prev === 1'b1 && mic_sck === 1'b0)
            begin
                if (ws_prev !== mic_ws)
                    fall_cnt = 0;
                else
                    fall_cnt = fall_cnt + 1;
                if (ws_prev === 1'b1 && mic_ws === 1'b0)
                    left_frames = left_frames + 1;
                if (fall_cnt >= 1 && fall_cnt <= 24)
                    mic_sd = mic_ws ? ~cur_sample[5'(24 - fall_cnt)]  // Right channel garbage.
                                    : cur_sample[5'(24 - fall_cnt)];
                else
                    mic_sd = 1'b0;
            end
            sck_prev = mic_sck;
            ws_prev  = mic_ws;
        end
    end

    initial
    begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns and was stopped.", timeout_ns);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        int          start;
        logic [31:0] rnd;
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        sw         = 5'h00;
        cur_sample = 24'h000000;
        cur_keys   = 8'h00;
        font = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
                 8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E};

        sample_tab[0] = 24'h000000;
        sw_tab[0]     = 5'h00;
        keys_tab[0]   = 8'h00;
        sample_tab[1] = 24'hFFFFFF;  // Every digit changes at once.
        sw_tab[1]     = 5'h1F;
        keys_tab[1]   = 8'hFF;
        sample_tab[2] = 24'h123ABC;
        sw_tab[2]     = 5'h18;
        keys_tab[2]   = 8'hA5;
        rnd           = xorshift(32'd94659);
        sample_tab[3] = rnd[23:0];
        sw_tab[3]     = rnd[28:24];
        rnd           = xorshift(rnd);
        keys_tab[3]   = rnd[7:0];
        rnd           = xorshift(rnd);
        sample_tab[4] = rnd[23:0];
        sw_tab[4]     = rnd[28:24];
        rnd           = xorshift(rnd);
        keys_tab[4]   = rnd[7:0];
        sample_tab[5] = 24'h456DE7;
        sw_tab[5]     = 5'h19;
        keys_tab[5]   = 8'h5A;

        repeat (reset_cycles) @(posedge clk);
        #2;
        check("sio_stb", 32'(sio_stb), 32'd1);
        check("sio_clk", 32'(sio_clk), 32'd1);
        check("sio_data_oe", 32'(sio_data_oe), 32'd0);
        check("mic_lr", 32'(mic_lr), 32'd0);
        check("mic_sck", 32'(mic_sck), 32'd0);
        check("mic_ws", 32'(mic_ws), 32'd0);
        rst_n = 1'b1;

        for (logic [2:0] e = 3'd0; e < 3'(n_entries); e++)
        begin
            @(posedge clk);
            #2;
            cur_sample = sample_tab[e];
            sw         = sw_tab[e];
            cur_keys   = keys_tab[e];
            start      = left_frames;
            wait (left_frames >= start + 2);  // One clean left frame captured.
            start = panel_frames;
            wait (panel_frames >= start + 2);  // Keys read, then a full refresh.
            check_entry(e);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/board_pkg.sv
logic/panel_if.sv
logic/inmp441_mic_i2s_receiver.sv
logic/mic_monitor.sv
logic/tm1638_board_controller.sv
logic/board_specific_top.sv
tb/tm1638_panel_model.sv
tb/tb_board_specific_top.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module tb_board_specific_top \
    -o tb_board_specific_top &&
out="$(./obj_dir/tb_board_specific_top)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "All tests passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
